//--- common/hci_bus_pkg.sv
/*
 * Request/response bus package
 * Field widths of the memory-side bus and the response opcode encoding
 */

`default_nettype none

package hci_bus_pkg;

  // Address and data widths
  localparam int unsigned AW = 32;
  localparam int unsigned DW = 32;

  // One byte enable per data byte
  localparam int unsigned BW = DW / 8;

  // Initiator id carried with each request
  localparam int unsigned IW = 4;

  // One-bit response opcode
  localparam logic OPC_OK  = 1'b0;
  localparam logic OPC_ERR = 1'b1;

endpackage

`default_nettype wire

//--- common/hci_rob_pkg.sv
/*
 * Reorder buffer package
 * Buffer depth, tag width, memory geometry and response latency constants
 */

`default_nettype none

package hci_rob_pkg;

  // Buffer slots with at most ROB_NW-1 of them in flight
  localparam int unsigned ROB_NW = 8;
  localparam int unsigned UW     = $clog2(ROB_NW);

  // Word memory indexed by address bits 7..2
  localparam int unsigned MEM_WORDS = 64;
  localparam int unsigned WIDX_W    = $clog2(MEM_WORDS);
  localparam int unsigned WIDX_LSB  = 2;
  localparam int unsigned WIDX_MSB  = WIDX_LSB + WIDX_W - 1;

  // Latency is LAT_BASE plus address bits 4..2
  localparam int unsigned LAT_BASE = 1;
  localparam int unsigned LAT_MSB  = 4;
  localparam int unsigned LAT_W    = $clog2(LAT_BASE + (1 << (LAT_MSB - WIDX_LSB + 1)));

endpackage

`default_nettype wire

//--- common/hci_ostd_intf.sv
/*
 * Outstanding request/response bus
 * Independent valid/ready handshakes for requests and responses,
 * with a user tag that the target returns unchanged
 */

`timescale 1ns/1ps
`default_nettype none

interface hci_ostd_intf
  import hci_bus_pkg::*;
  import hci_rob_pkg::*;
();

  // Request channel
  logic          req_valid;
  logic          req_ready;
  logic [AW-1:0] req_add;
  logic          req_wen;    // high for a read
  logic [BW-1:0] req_be;
  logic [DW-1:0] req_data;
  logic [IW-1:0] req_id;
  logic [UW-1:0] req_user;

  // Response channel
  logic          resp_valid;
  logic          resp_ready;
  logic [DW-1:0] resp_data;
  logic          resp_opc;
  logic [IW-1:0] resp_id;
  logic [UW-1:0] resp_user;

  modport initiator (
    output req_valid, req_add, req_wen, req_be, req_data, req_id, req_user,
    input  req_ready,
    input  resp_valid, resp_data, resp_opc, resp_id, resp_user,
    output resp_ready
  );

  modport target (
    input  req_valid, req_add, req_wen, req_be, req_data, req_id, req_user,
    output req_ready,
    output resp_valid, resp_data, resp_opc, resp_id, resp_user,
    input  resp_ready
  );

endinterface

`default_nettype wire

//--- hci_rob/hci_rob.sv
/*
 * Reorder buffer
 * Tags each forwarded request with a slot index, stores out-of-order
 * responses under their returned tag and retires them in issue order
 */

`timescale 1ns/1ps
`default_nettype none

module hci_rob
  import hci_bus_pkg::*;
  import hci_rob_pkg::*;
(
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  hci_ostd_intf.target    in,
  hci_ostd_intf.initiator out
);

  // Issue and retire pointers, occupancy
  logic [UW-1:0] wr_ptr_q;
  logic [UW-1:0] rd_ptr_q;
  logic [UW-1:0] cnt_q;

  logic full;
  logic empty;
  logic req_fire;
  logic rsp_push;
  logic rsp_pop;

  // Per-slot stores
  logic [IW-1:0]     id_q   [ROB_NW];
  logic [DW-1:0]     data_q [ROB_NW];
  logic [ROB_NW-1:0] opc_q;
  logic [ROB_NW-1:0] valid_q;

  // Pointer step with wrap at the last slot
  function automatic logic [UW-1:0] ptr_inc(input logic [UW-1:0] ptr);
    return (ptr == UW'(ROB_NW - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full  = (cnt_q == UW'(ROB_NW - 1));
  assign empty = (cnt_q == '0);

  // Request path goes straight through, gated by full
  assign out.req_valid = in.req_valid & ~full;
  assign out.req_add   = in.req_add;
  assign out.req_wen   = in.req_wen;
  assign out.req_be    = in.req_be;
  assign out.req_data  = in.req_data;
  assign out.req_id    = in.req_id;
  assign out.req_user  = wr_ptr_q;
  assign in.req_ready  = out.req_ready & ~full;

  // Only the head slot is ever shown
  assign in.resp_valid = valid_q[rd_ptr_q];
  assign in.resp_data  = data_q[rd_ptr_q];
  assign in.resp_opc   = opc_q[rd_ptr_q];
  assign in.resp_id    = id_q[rd_ptr_q];
  assign in.resp_user  = '0;

  // Memory responses accepted whenever something is in flight
  assign out.resp_ready = ~empty;

  assign req_fire = in.req_valid & in.req_ready;
  assign rsp_push = out.resp_valid & out.resp_ready;
  assign rsp_pop  = valid_q[rd_ptr_q] & in.resp_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      valid_q  <= '0;
    end else begin
      if (req_fire) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (rsp_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // Issue and retire in the same cycle leave the count alone
      case ({req_fire, rsp_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
      // Returned tag marks its slot ready
      if (rsp_push) begin
        valid_q[out.resp_user] <= 1'b1;
      end
      // Head cleared on retire
      if (rsp_pop) begin
        valid_q[rd_ptr_q] <= 1'b0;
      end
    end
  end

  // Slot payloads
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      id_q[wr_ptr_q] <= in.req_id;
    end
    if (rsp_push) begin
      data_q[out.resp_user] <= out.resp_data;
      opc_q[out.resp_user]  <= out.resp_opc;
    end
  end

endmodule

`default_nettype wire

//--- mem_target/sram_bank.sv
/*
 * Word memory bank
 * Byte-enabled register array with combinational read and
 * out-of-range detection
 */

`timescale 1ns/1ps
`default_nettype none

module sram_bank
  import hci_bus_pkg::*;
  import hci_rob_pkg::*;
(
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire logic          we,
  input  wire logic          en,
  input  wire logic [AW-1:0] add,
  input  wire logic [BW-1:0] be,
  input  wire logic [DW-1:0] wdata,
  output logic      [DW-1:0] rdata,
  output logic               oor
);

  logic [DW-1:0]     mem_q [MEM_WORDS];
  logic [WIDX_W-1:0] widx;

  assign widx = add[WIDX_MSB:WIDX_LSB];

  // Any address bit above the index is out of range
  assign oor   = |add[AW-1:WIDX_MSB+1];
  assign rdata = oor ? '0 : mem_q[widx];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '{default: '0};
    end else if (en && we && !oor) begin
      // Enabled bytes only
      for (int b = 0; b < BW; b++) begin
        if (be[b]) begin
          mem_q[widx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- mem_target/resp_delay_slots.sv
/*
 * Response delay slots
 * Holds each memory answer for an address-dependent latency and
 * returns the lowest finished slot, tag unchanged
 */

`timescale 1ns/1ps
`default_nettype none

module resp_delay_slots
  import hci_bus_pkg::*;
  import hci_rob_pkg::*;
(
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  hci_ostd_intf.target       tgt,
  input  wire logic [DW-1:0] rdata,
  input  wire logic          oor
);

  // Slot state
  logic [ROB_NW-1:0] valid_q;
  logic [LAT_W-1:0]  cnt_q  [ROB_NW];
  logic [DW-1:0]     data_q [ROB_NW];
  logic [IW-1:0]     id_q   [ROB_NW];
  logic [UW-1:0]     tag_q  [ROB_NW];
  logic [ROB_NW-1:0] opc_q;

  logic [ROB_NW-1:0] done;
  logic [UW-1:0]     free_idx;
  logic [UW-1:0]     sel_idx;
  logic              load;
  logic              drain;
  logic [LAT_W-1:0]  lat;

  // Finished when countdown is at zero
  always_comb begin
    for (int i = 0; i < ROB_NW; i++) begin
      done[i] = valid_q[i] & (cnt_q[i] == '0);
    end
  end

  // Lowest free and lowest finished slot
  always_comb begin
    free_idx = '0;
    sel_idx  = '0;
    for (int i = ROB_NW - 1; i >= 0; i--) begin
      if (!valid_q[i]) free_idx = UW'(i);
      if (done[i])     sel_idx  = UW'(i);
    end
  end

  assign lat = LAT_W'(LAT_BASE) + LAT_W'(tgt.req_add[LAT_MSB:WIDX_LSB]);

  assign tgt.req_ready  = ~&valid_q;
  assign load           = tgt.req_valid & tgt.req_ready;

  assign tgt.resp_valid = |done;
  assign tgt.resp_data  = data_q[sel_idx];
  assign tgt.resp_opc   = opc_q[sel_idx];
  assign tgt.resp_id    = id_q[sel_idx];
  assign tgt.resp_user  = tag_q[sel_idx];
  assign drain          = tgt.resp_valid & tgt.resp_ready;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      cnt_q   <= '{default: '0};
    end else begin
      // Count every occupied slot down
      for (int i = 0; i < ROB_NW; i++) begin
        if (valid_q[i] && (cnt_q[i] != '0)) begin
          cnt_q[i] <= cnt_q[i] - 1'b1;
        end
      end
      if (drain) begin
        valid_q[sel_idx] <= 1'b0;
      end
      // New request takes a free slot, never the draining one
      if (load) begin
        valid_q[free_idx] <= 1'b1;
        cnt_q[free_idx]   <= lat;
      end
    end
  end

  // Answer captured at request time
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q[free_idx] <= (oor || tgt.req_wen) ? rdata : tgt.req_data;
      opc_q[free_idx]  <= oor ? OPC_ERR : OPC_OK;
      id_q[free_idx]   <= tgt.req_id;
      tag_q[free_idx]  <= tgt.req_user;
    end
  end

endmodule

`default_nettype wire

//--- source/hci_rob_subsys.sv
/*
 * Reorder buffer subsystem
 * Reorder buffer in front of a word memory whose delayed answers
 * come back out of order
 */

`timescale 1ns/1ps
`default_nettype none

module hci_rob_subsys
  import hci_bus_pkg::*;
(
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  // Request
  input  wire logic          req_valid,
  output logic               req_ready,
  input  wire logic [AW-1:0] req_add,
  input  wire logic          req_wen,
  input  wire logic [BW-1:0] req_be,
  input  wire logic [DW-1:0] req_data,
  input  wire logic [IW-1:0] req_id,
  // Response
  output logic               resp_valid,
  input  wire logic          resp_ready,
  output logic      [DW-1:0] resp_data,
  output logic               resp_opc,
  output logic      [IW-1:0] resp_id
);

  hci_ostd_intf host ();
  hci_ostd_intf mem_bus ();

  logic [DW-1:0] bank_rdata;
  logic          bank_oor;
  logic          mem_fire;

  // Plain ports onto the host bus
  assign host.req_valid  = req_valid;
  assign host.req_add    = req_add;
  assign host.req_wen    = req_wen;
  assign host.req_be     = req_be;
  assign host.req_data   = req_data;
  assign host.req_id     = req_id;
  assign host.req_user   = '0;
  assign req_ready       = host.req_ready;

  assign resp_valid      = host.resp_valid;
  assign resp_data       = host.resp_data;
  assign resp_opc        = host.resp_opc;
  assign resp_id         = host.resp_id;
  assign host.resp_ready = resp_ready;

  hci_rob u_hci_rob (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .in     (host.target),
    .out    (mem_bus.initiator)
  );

  // Bank access on the request transfer cycle
  assign mem_fire = mem_bus.req_valid & mem_bus.req_ready;

  sram_bank u_sram_bank (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .we     (~mem_bus.req_wen),
    .en     (mem_fire),
    .add    (mem_bus.req_add),
    .be     (mem_bus.req_be),
    .wdata  (mem_bus.req_data),
    .rdata  (bank_rdata),
    .oor    (bank_oor)
  );

  resp_delay_slots u_resp_delay_slots (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .tgt    (mem_bus.target),
    .rdata  (bank_rdata),
    .oor    (bank_oor)
  );

endmodule

`default_nettype wire

//--- verif/tb_hci_rob_subsys.sv
/*
 * Testbench for the reorder buffer subsystem
 * Applies a table of directed requests, a full-buffer stall and a random
 * burst, and checks every response against a shadow memory in issue order
 */

`timescale 1ns/1ps
`default_nettype none

module tb_hci_rob_subsys
  import hci_bus_pkg::*;
  import hci_rob_pkg::*;
();

  localparam int unsigned WAIT_MAX  = 200;
  localparam int unsigned DRAIN_MAX = 1000;
  localparam int unsigned RAND_N    = 48;

  logic          clk_i;
  logic          rst_ni;
  logic          req_valid;
  logic          req_ready;
  logic [AW-1:0] req_add;
  logic          req_wen;
  logic [BW-1:0] req_be;
  logic [DW-1:0] req_data;
  logic [IW-1:0] req_id;
  logic          resp_valid;
  logic          resp_ready;
  logic [DW-1:0] resp_data;
  logic          resp_opc;
  logic [IW-1:0] resp_id;

  // Directed stimulus table with one row per request
  string         tbl_name [$];
  logic [AW-1:0] tbl_add  [$];
  logic          tbl_rd   [$];
  logic [BW-1:0] tbl_be   [$];
  logic [DW-1:0] tbl_data [$];
  logic [IW-1:0] tbl_id   [$];
  logic          tbl_opc  [$];

  // Expected responses with the oldest first
  string         exp_name [$];
  logic [DW-1:0] exp_data [$];
  logic          exp_opc  [$];
  logic [IW-1:0] exp_id   [$];

  logic [DW-1:0] shadow [MEM_WORDS];
  logic [31:0]   stim_seed;
  logic [31:0]   stall_seed;
  logic          hold_resp;
  logic          stall_en;
  int            pass_cnt;
  int            err_cnt;

  hci_rob_subsys u_hci_rob_subsys (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .req_add    (req_add),
    .req_wen    (req_wen),
    .req_be     (req_be),
    .req_data   (req_data),
    .req_id     (req_id),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_data  (resp_data),
    .resp_opc   (resp_opc),
    .resp_id    (resp_id)
  );

  // 8 ns clock
  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_seed = lcg_step(stim_seed);
    return stim_seed;
  endfunction

  task automatic add_row(input string name, input logic [AW-1:0] add, input logic rd,
                         input logic [BW-1:0] be, input logic [DW-1:0] data,
                         input logic [IW-1:0] id, input logic opc);
    tbl_name.push_back(name);
    tbl_add.push_back(add);
    tbl_rd.push_back(rd);
    tbl_be.push_back(be);
    tbl_data.push_back(data);
    tbl_id.push_back(id);
    tbl_opc.push_back(opc);
  endtask

  task automatic build_table();
    // Memory is still all zero
    add_row("rd_after_reset",    32'h0000_0014, 1'b1, 4'hf, '0, 4'd1, OPC_OK);
    add_row("rd_after_reset_hi", 32'h0000_00fc, 1'b1, 4'hf, '0, 4'd2, OPC_OK);
    // Long latency first so short ones overtake inside the memory
    add_row("wr_lat8", 32'h0000_001c, 1'b0, 4'hf, next_stim(), 4'd3, OPC_OK);
    add_row("wr_lat1", 32'h0000_0000, 1'b0, 4'hf, next_stim(), 4'd4, OPC_OK);
    add_row("wr_lat3", 32'h0000_0008, 1'b0, 4'hf, next_stim(), 4'd5, OPC_OK);
    add_row("wr_lat2", 32'h0000_0044, 1'b0, 4'hf, next_stim(), 4'd6, OPC_OK);
    add_row("rd_lat8", 32'h0000_001c, 1'b1, 4'hf, '0, 4'd7,  OPC_OK);
    add_row("rd_lat1", 32'h0000_0000, 1'b1, 4'hf, '0, 4'd8,  OPC_OK);
    add_row("rd_lat3", 32'h0000_0008, 1'b1, 4'hf, '0, 4'd9,  OPC_OK);
    add_row("rd_lat2", 32'h0000_0044, 1'b1, 4'hf, '0, 4'd10, OPC_OK);
    // Byte lanes merge into one word
    add_row("wr_be_1111", 32'h0000_0030, 1'b0, 4'hf, next_stim(), 4'd11, OPC_OK);
    add_row("wr_be_0101", 32'h0000_0030, 1'b0, 4'h5, next_stim(), 4'd12, OPC_OK);
    add_row("wr_be_1000", 32'h0000_0030, 1'b0, 4'h8, next_stim(), 4'd13, OPC_OK);
    add_row("rd_merged",  32'h0000_0030, 1'b1, 4'hf, '0, 4'd14, OPC_OK);
    // Out of range addresses
    // 0x100 would alias word 0 if bit 8 were ignored
    add_row("wr_oor",    32'h0000_0100, 1'b0, 4'hf, next_stim(), 4'd15, OPC_ERR);
    add_row("rd_oor",    32'h0000_0100, 1'b1, 4'hf, '0, 4'd0, OPC_ERR);
    add_row("wr_oor_hi", 32'h8000_0000, 1'b0, 4'hf, next_stim(), 4'd1, OPC_ERR);
    add_row("rd_alias",  32'h0000_0000, 1'b1, 4'hf, '0, 4'd2, OPC_OK);
  endtask

  // Starts and ends on a falling edge
  task automatic send(input string name, input logic [AW-1:0] add, input logic rd,
                      input logic [BW-1:0] be, input logic [DW-1:0] data,
                      input logic [IW-1:0] id, input logic opc);
    int unsigned       n;
    logic [DW-1:0]     exp_d;
    logic [WIDX_W-1:0] idx;
    n   = 0;
    idx = add[WIDX_MSB:WIDX_LSB];
    req_valid = 1'b1;
    req_add   = add;
    req_wen   = rd;
    req_be    = be;
    req_data  = data;
    req_id    = id;
    // Ready comes from registered state and is settled by the falling edge
    while (!req_ready && n < WAIT_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (!req_ready) begin
      $display("Timeout: request %s was never accepted", name);
      err_cnt++;
    end else begin
      // Writes echo their own data word
      if (add[AW-1:WIDX_MSB+1] != '0) begin
        exp_d = '0;
      end else if (rd) begin
        exp_d = shadow[idx];
      end else begin
        exp_d = data;
        for (int b = 0; b < BW; b++) begin
          if (be[b]) shadow[idx][8*b +: 8] = data[8*b +: 8];
        end
      end
      exp_name.push_back(name);
      exp_data.push_back(exp_d);
      exp_opc.push_back(opc);
      exp_id.push_back(id);
      @(negedge clk_i);
    end
    req_valid = 1'b0;
  endtask

  task automatic random_request(input int k);
    logic [31:0]   r;
    logic [AW-1:0] add;
    logic [BW-1:0] be;
    logic          oor;
    r   = next_stim();
    add = {24'h00_0000, r[27:22], 2'b00};
    oor = (r[31:29] == 3'd0);
    // Roughly one in eight goes out of range
    if (oor) add[AW-1:8] = {8'h00, r[27:12]} | 24'h00_0001;
    be = r[19:16];
    if (be == '0) be = '1;
    send($sformatf("rand_%0d", k), add, r[20], be, next_stim(), r[15:12],
         oor ? OPC_ERR : OPC_OK);
  endtask

  task automatic wait_drain(input string what);
    int unsigned n;
    n = 0;
    while (exp_name.size() != 0 && n < DRAIN_MAX) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_name.size() != 0) begin
      $display("Timeout: %0d responses of %s never came back", exp_name.size(), what);
      err_cnt++;
      exp_name.delete();
      exp_data.delete();
      exp_opc.delete();
      exp_id.delete();
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    assert (actual === expected) begin
      pass_cnt++;
      $display("ok    %s", name);
    end else begin
      err_cnt++;
      $display("ERROR %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic check_response();
    string         name;
    logic [DW-1:0] d;
    logic          o;
    logic [IW-1:0] i;
    if (exp_name.size() == 0) begin
      $display("Response with id %0d arrived while no request was pending", resp_id);
      err_cnt++;
    end else begin
      name = exp_name.pop_front();
      d    = exp_data.pop_front();
      o    = exp_opc.pop_front();
      i    = exp_id.pop_front();
      assert (resp_data === d && resp_opc === o && resp_id === i) begin
        pass_cnt++;
        $display("ok    %s", name);
      end else begin
        err_cnt++;
        $display("ERROR %s: expected data %h opc %0d id %0d, actual data %h opc %0d id %0d",
                 name, d, o, i, resp_data, resp_opc, resp_id);
      end
    end
  endtask

  // Receiver drives resp_ready and checks on the falling edge
  initial begin : receive
    resp_ready = 1'b0;
    forever begin
      @(negedge clk_i);
      if (hold_resp || !rst_ni) begin
        resp_ready = 1'b0;
      end else if (stall_en) begin
        stall_seed = lcg_step(stall_seed);
        resp_ready = stall_seed[30] | stall_seed[27];
      end else begin
        resp_ready = 1'b1;
      end
      if (rst_ni && resp_valid && resp_ready) check_response();
    end
  end

  initial begin : main
    rst_ni     = 1'b0;
    req_valid  = 1'b0;
    req_add    = '0;
    req_wen    = 1'b1;
    req_be     = '0;
    req_data   = '0;
    req_id     = '0;
    stim_seed  = 32'd28;
    stall_seed = 32'd28;
    hold_resp  = 1'b0;
    stall_en   = 1'b0;
    pass_cnt   = 0;
    err_cnt    = 0;
    for (int w = 0; w < MEM_WORDS; w++) shadow[w] = '0;

    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("reset_resp_valid", resp_valid, 1'b0);
    check_flag("reset_req_ready", req_ready, 1'b1);

    build_table();
    for (int r = 0; r < tbl_name.size(); r++) begin
      send(tbl_name[r], tbl_add[r], tbl_rd[r], tbl_be[r], tbl_data[r], tbl_id[r],
           tbl_opc[r]);
    end
    wait_drain("directed table");

    // Initiator stalls while the buffer fills to ROB_NW-1
    hold_resp = 1'b1;
    for (int i = 0; i < ROB_NW - 1; i++) begin
      send($sformatf("fill_%0d", i), AW'(32'h40 + 4 * i), 1'b1, 4'hf, '0, IW'(i), OPC_OK);
    end
    repeat (4) @(negedge clk_i);
    check_flag("full_req_ready", req_ready, 1'b0);
    hold_resp = 1'b0;
    wait_drain("full buffer");
    @(negedge clk_i);
    check_flag("release_req_ready", req_ready, 1'b1);

    // Random traffic with random initiator stalls
    stall_en = 1'b1;
    for (int k = 0; k < RAND_N; k++) random_request(k);
    wait_drain("random burst");
    stall_en = 1'b0;
    @(negedge clk_i);

    $display("%0d tests, %0d passed, %0d failed", pass_cnt + err_cnt, pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
common/hci_bus_pkg.sv
common/hci_rob_pkg.sv
common/hci_ostd_intf.sv
hci_rob/hci_rob.sv
mem_target/sram_bank.sv
mem_target/resp_delay_slots.sv
source/hci_rob_subsys.sv
verif/tb_hci_rob_subsys.sv

//--- Bender.yml
package:
  name: hci_rob_subsys

sources:
  - common/hci_bus_pkg.sv
  - common/hci_rob_pkg.sv
  - common/hci_ostd_intf.sv
  - hci_rob/hci_rob.sv
  - mem_target/sram_bank.sv
  - mem_target/resp_delay_slots.sv
  - source/hci_rob_subsys.sv
  - target: test
    files:
      - verif/tb_hci_rob_subsys.sv
